// ==== cmd_frame_pkg.sv ====
package cmd_frame_pkg;

    localparam int udp_word_w = 32;            // one udp receive word

    localparam logic [7:0] op_addr  = 8'h00;   // address command frame
    localparam logic [7:0] op_wdata = 8'hFF;   // write data frame

    // parser frame states
    localparam logic [1:0] frm_idle = 2'd0;
    localparam logic [1:0] frm_addr = 2'd1;
    localparam logic [1:0] frm_skip = 2'd2;

    typedef struct packed {
        logic [udp_word_w-1:0] hi;              // first word on the wire
        logic [udp_word_w-1:0] lo;
    } cmd_words_t;

    typedef struct packed {
        logic [7:0]  opcode;
        logic [1:0]  burst;
        logic [1:0]  id;
        logic [2:0]  rsvd_a;
        logic        wr;                        // 1 write, 0 read
        logic [7:0]  len;
        logic [7:0]  rsvd_b;
        logic [31:0] addr;
    } cmd_fields_t;

    // one 64-bit head seen as raw words or as decoded fields
    typedef union packed {
        cmd_words_t  words;
        cmd_fields_t fields;
    } cmd_head_t;

endpackage

// ==== axi_addr_pkg.sv ====
package axi_addr_pkg;

    localparam int axi_id_w    = 2;
    localparam int axi_addr_w  = 32;
    localparam int axi_len_w   = 8;     // beats minus one
    localparam int axi_burst_w = 2;

    localparam int head_q_depth = 16;   // power of two, pointers wrap naturally

    typedef logic [axi_id_w-1:0]    axi_id_t;
    typedef logic [axi_addr_w-1:0]  axi_addr_t;
    typedef logic [axi_len_w-1:0]   axi_len_t;
    typedef logic [axi_burst_w-1:0] axi_burst_t;

endpackage

// ==== head_q_if.sv ====
`timescale 1ns/10ps

interface head_q_if import cmd_frame_pkg::*; ();

    logic      push;        // one-cycle strobe, only while full is low
    cmd_head_t push_head;
    logic      full;
    logic      pop;         // one-cycle strobe, only while empty is low
    cmd_head_t pop_head;    // oldest entry, show-ahead
    logic      empty;

    modport producer (output push, output push_head, input full);

    modport buffer (input push, input push_head, input pop,
                    output full, output pop_head, output empty);

    modport consumer (output pop, input pop_head, input empty);

endinterface

// ==== cmd_frame_parser.sv ====
`timescale 1ns/10ps

module cmd_frame_parser
    import cmd_frame_pkg::*;
(
    input  logic                  gmii_rx_clk,
    input  logic                  rstn,
    input  logic                  udp_rx_en,
    input  logic [udp_word_w-1:0] udp_rx_data,
    input  logic                  udp_rx_done,
    head_q_if.producer            q,
    output logic                  cmd_drop
);

    logic [1:0] frm_state;
    logic [7:0] first_op;
    logic       take_word;
    logic       word_ph;    // 0 expects hi word, 1 expects lo word
    logic       head_rdy;   // head_asm complete this cycle
    logic       head_ok;
    cmd_head_t  head_asm;

    assign first_op  = udp_rx_data[udp_word_w-1 -: 8];
    assign take_word = udp_rx_en && ((frm_state == frm_addr) ||
                       (frm_state == frm_idle && first_op == op_addr));
    assign head_ok   = head_rdy && (head_asm.fields.opcode == op_addr);

    // frame type is picked by the opcode of the first word
    always_ff @(posedge gmii_rx_clk or negedge rstn) begin
        if (!rstn) begin
            frm_state <= frm_idle;
        end else if (udp_rx_en) begin
            case (frm_state)
                frm_idle: begin
                    if (!udp_rx_done) begin  // single word frame stays idle
                        case (first_op)
                            op_addr:  frm_state <= frm_addr;
                            default:  frm_state <= frm_skip;   // write data not forwarded
                        endcase
                    end
                end
                default: begin
                    if (udp_rx_done)
                        frm_state <= frm_idle;
                end
            endcase
        end
    end

    always_ff @(posedge gmii_rx_clk or negedge rstn) begin
        if (!rstn) begin
            word_ph  <= 1'b0;
            head_rdy <= 1'b0;
        end else begin
            head_rdy <= take_word && word_ph;
            if (udp_rx_en && udp_rx_done)
                word_ph <= 1'b0;            // odd trailing word is dropped
            else if (take_word)
                word_ph <= ~word_ph;
        end
    end

    always_ff @(posedge gmii_rx_clk) begin
        if (take_word) begin
            if (word_ph)
                head_asm.words.lo <= udp_rx_data;
            else
                head_asm.words.hi <= udp_rx_data;
        end
    end

    // push stage, separate copy so the next hi word can land in head_asm
    always_ff @(posedge gmii_rx_clk or negedge rstn) begin
        if (!rstn) begin
            q.push   <= 1'b0;
            cmd_drop <= 1'b0;
        end else begin
            q.push   <= head_ok && !q.full;
            cmd_drop <= head_ok && q.full;   // queue full, head lost
        end
    end

    always_ff @(posedge gmii_rx_clk) begin
        if (head_rdy)
            q.push_head <= head_asm;
    end

endmodule

// ==== cmd_head_fifo.sv ====
`timescale 1ns/10ps

module cmd_head_fifo
    import cmd_frame_pkg::*, axi_addr_pkg::*;
(
    input  logic      gmii_rx_clk,
    input  logic      rstn,
    head_q_if.buffer  q
);

    cmd_head_t                         mem [head_q_depth];
    logic [$clog2(head_q_depth)-1:0]   wr_ptr;
    logic [$clog2(head_q_depth)-1:0]   rd_ptr;
    logic [$clog2(head_q_depth):0]     count;
    logic                              do_wr;
    logic                              do_rd;

    assign do_wr = q.push && !q.full;
    assign do_rd = q.pop && !q.empty;

    always_ff @(posedge gmii_rx_clk) begin
        if (do_wr)
            mem[wr_ptr] <= q.push_head;
    end

    always_ff @(posedge gmii_rx_clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
            if (do_rd)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // none or both
            endcase
        end
    end

    assign q.pop_head = mem[rd_ptr];        // show-ahead read
    assign q.full     = (count == head_q_depth);
    assign q.empty    = (count == '0);

endmodule

// ==== axi_addr_issuer.sv ====
`timescale 1ns/10ps

module axi_addr_issuer
    import cmd_frame_pkg::*, axi_addr_pkg::*;
(
    input  logic        gmii_rx_clk,
    input  logic        rstn,
    head_q_if.consumer  q,

    output axi_id_t     wr_addr_id,
    output axi_addr_t   wr_addr,
    output axi_len_t    wr_addr_len,
    output axi_burst_t  wr_addr_burst,
    output logic        wr_addr_valid,
    input  logic        wr_addr_ready,

    output axi_id_t     rd_addr_id,
    output axi_addr_t   rd_addr,
    output axi_len_t    rd_addr_len,
    output axi_burst_t  rd_addr_burst,
    output logic        rd_addr_valid,
    input  logic        rd_addr_ready
);

    logic      issuing;     // 0 idle, 1 issue
    logic      xfer;
    cmd_head_t head_hold;

    assign xfer  = (wr_addr_valid && wr_addr_ready) ||
                   (rd_addr_valid && rd_addr_ready);
    assign q.pop = !issuing && !q.empty;

    always_ff @(posedge gmii_rx_clk or negedge rstn) begin
        if (!rstn) begin
            issuing       <= 1'b0;
            wr_addr_valid <= 1'b0;
            rd_addr_valid <= 1'b0;
        end else if (q.pop) begin
            issuing       <= 1'b1;
            wr_addr_valid <= q.pop_head.fields.wr;   // channel from wr flag
            rd_addr_valid <= !q.pop_head.fields.wr;
        end else if (xfer) begin
            issuing       <= 1'b0;   // one idle cycle before next pop
            wr_addr_valid <= 1'b0;
            rd_addr_valid <= 1'b0;
        end
    end

    // only loads while idle, so fields hold steady under valid
    always_ff @(posedge gmii_rx_clk) begin
        if (q.pop)
            head_hold <= q.pop_head;
    end

    assign wr_addr_id    = head_hold.fields.id;
    assign wr_addr       = head_hold.fields.addr;
    assign wr_addr_len   = head_hold.fields.len;
    assign wr_addr_burst = head_hold.fields.burst;

    assign rd_addr_id    = head_hold.fields.id;
    assign rd_addr       = head_hold.fields.addr;
    assign rd_addr_len   = head_hold.fields.len;
    assign rd_addr_burst = head_hold.fields.burst;

endmodule

// ==== udp_axi_cmd.sv ====
`timescale 1ns/10ps

module udp_axi_cmd
    import cmd_frame_pkg::*, axi_addr_pkg::*;
(
    input  logic                  gmii_rx_clk,
    input  logic                  rstn,

    input  logic                  udp_rx_en,
    input  logic [udp_word_w-1:0] udp_rx_data,
    input  logic                  udp_rx_done,

    output axi_id_t               wr_addr_id,
    output axi_addr_t             wr_addr,
    output axi_len_t              wr_addr_len,
    output axi_burst_t            wr_addr_burst,
    output logic                  wr_addr_valid,
    input  logic                  wr_addr_ready,

    output axi_id_t               rd_addr_id,
    output axi_addr_t             rd_addr,
    output axi_len_t              rd_addr_len,
    output axi_burst_t            rd_addr_burst,
    output logic                  rd_addr_valid,
    input  logic                  rd_addr_ready,

    output logic                  cmd_drop
);

    head_q_if u_head_q ();

    cmd_frame_parser u_parser (
        .gmii_rx_clk (gmii_rx_clk),
        .rstn        (rstn),
        .udp_rx_en   (udp_rx_en),
        .udp_rx_data (udp_rx_data),
        .udp_rx_done (udp_rx_done),
        .q           (u_head_q.producer),
        .cmd_drop    (cmd_drop)
    );

    cmd_head_fifo u_fifo (
        .gmii_rx_clk (gmii_rx_clk),
        .rstn        (rstn),
        .q           (u_head_q.buffer)
    );

    axi_addr_issuer u_issuer (
        .gmii_rx_clk   (gmii_rx_clk),
        .rstn          (rstn),
        .q             (u_head_q.consumer),
        .wr_addr_id    (wr_addr_id),
        .wr_addr       (wr_addr),
        .wr_addr_len   (wr_addr_len),
        .wr_addr_burst (wr_addr_burst),
        .wr_addr_valid (wr_addr_valid),
        .wr_addr_ready (wr_addr_ready),
        .rd_addr_id    (rd_addr_id),
        .rd_addr       (rd_addr),
        .rd_addr_len   (rd_addr_len),
        .rd_addr_burst (rd_addr_burst),
        .rd_addr_valid (rd_addr_valid),
        .rd_addr_ready (rd_addr_ready)
    );

endmodule

// ==== udp_axi_cmd_chk.sv ====
`timescale 1ns/10ps

module udp_axi_cmd_chk import axi_addr_pkg::*; (
    input logic       gmii_rx_clk,
    input logic       rstn,
    input axi_id_t    wr_addr_id,
    input axi_addr_t  wr_addr,
    input axi_len_t   wr_addr_len,
    input axi_burst_t wr_addr_burst,
    input logic       wr_addr_valid,
    input logic       wr_addr_ready,
    input axi_id_t    rd_addr_id,
    input axi_addr_t  rd_addr,
    input axi_len_t   rd_addr_len,
    input axi_burst_t rd_addr_burst,
    input logic       rd_addr_valid,
    input logic       rd_addr_ready
);

    int          fails = 0;     // failed assertion count
    logic [43:0] wr_fields;
    logic [43:0] rd_fields;
    logic        xfer;

    assign wr_fields = {wr_addr_id, wr_addr, wr_addr_len, wr_addr_burst};
    assign rd_fields = {rd_addr_id, rd_addr, rd_addr_len, rd_addr_burst};
    assign xfer      = (wr_addr_valid && wr_addr_ready) || (rd_addr_valid && rd_addr_ready);

    wr_hold: assert property (@(posedge gmii_rx_clk) disable iff (!rstn)
        wr_addr_valid && !wr_addr_ready |=> wr_addr_valid && $stable(wr_fields))
    else begin
        $error("write address channel changed while stalled");
        fails++;
    end

    rd_hold: assert property (@(posedge gmii_rx_clk) disable iff (!rstn)
        rd_addr_valid && !rd_addr_ready |=> rd_addr_valid && $stable(rd_fields))
    else begin
        $error("read address channel changed while stalled");
        fails++;
    end

    one_valid: assert property (@(posedge gmii_rx_clk) disable iff (!rstn)
        !(wr_addr_valid && rd_addr_valid))
    else begin
        $error("both address valids high together");
        fails++;
    end

    gap_after_xfer: assert property (@(posedge gmii_rx_clk) disable iff (!rstn)
        xfer |=> !wr_addr_valid && !rd_addr_valid)
    else begin
        $error("address valid high right after a transfer");
        fails++;
    end

endmodule

bind axi_addr_issuer udp_axi_cmd_chk u_chk (.*);

// ==== udp_axi_cmd_monitor.sv ====
`timescale 1ns/10ps

module udp_axi_cmd_monitor import axi_addr_pkg::*; (
    input logic       gmii_rx_clk,
    input logic       rstn,
    input axi_id_t    wr_addr_id,
    input axi_addr_t  wr_addr,
    input axi_len_t   wr_addr_len,
    input axi_burst_t wr_addr_burst,
    input logic       wr_addr_valid,
    input logic       wr_addr_ready,
    input axi_id_t    rd_addr_id,
    input axi_addr_t  rd_addr,
    input axi_len_t   rd_addr_len,
    input axi_burst_t rd_addr_burst,
    input logic       rd_addr_valid,
    input logic       rd_addr_ready,
    input logic       cmd_drop
);

    logic [44:0] exp_q [$];     // {wr, id, addr, len, burst}, oldest first
    string       cur_test = "";
    int          test_err = 0;
    int          drops    = 0;  // cmd_drop pulses in this test
    int          n_pass   = 0;
    int          n_fail   = 0;

    task automatic start_test(input string name);
        cur_test = name;
        test_err = 0;
        drops    = 0;
    endtask

    task automatic expect_item(input logic [44:0] item);
        exp_q.push_back(item);
    endtask

    function automatic int pending();
        return exp_q.size();
    endfunction

    task automatic check_value(input string what, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("FAIL %s %s: expected %0h, actual %0h", cur_test, what, exp, act);
            test_err++;
        end
    endtask

    task automatic report_error(input string msg);
        $display("ERROR %s: %s", cur_test, msg);
        test_err++;
    endtask

    task automatic finish_test(input int exp_drops);
        check_value("cmd_drop pulses", exp_drops, drops);
        if (exp_q.size() != 0) begin
            report_error($sformatf("%0d expected transfers never happened", exp_q.size()));
            exp_q.delete();
        end
        if (test_err == 0) begin
            $display("PASS %s", cur_test);
            n_pass++;
        end else begin
            $display("FAIL %s: %0d errors", cur_test, test_err);
            n_fail++;
        end
    endtask

    task automatic compare_xfer(input logic [44:0] act, input string chan);
        if (exp_q.size() == 0)
            report_error({"unexpected extra transfer on the ", chan, " address channel"});
        else
            check_value({chan, " address"}, exp_q.pop_front(), act);
    endtask

    always @(posedge gmii_rx_clk) begin
        if (rstn) begin
            if (cmd_drop)
                drops++;
            if (wr_addr_valid && wr_addr_ready)
                compare_xfer({1'b1, wr_addr_id, wr_addr, wr_addr_len, wr_addr_burst}, "write");
            if (rd_addr_valid && rd_addr_ready)
                compare_xfer({1'b0, rd_addr_id, rd_addr, rd_addr_len, rd_addr_burst}, "read");
        end
    end

endmodule

// ==== tb_udp_axi_cmd.sv ====
`timescale 1ns/10ps

module tb_udp_axi_cmd import cmd_frame_pkg::*, axi_addr_pkg::*; ();

    logic                  gmii_rx_clk;
    logic                  rstn;
    logic                  udp_rx_en;
    logic [udp_word_w-1:0] udp_rx_data;
    logic                  udp_rx_done;
    axi_id_t               wr_addr_id;
    axi_addr_t             wr_addr;
    axi_len_t              wr_addr_len;
    axi_burst_t            wr_addr_burst;
    logic                  wr_addr_valid;
    logic                  wr_addr_ready;
    axi_id_t               rd_addr_id;
    axi_addr_t             rd_addr;
    axi_len_t              rd_addr_len;
    axi_burst_t            rd_addr_burst;
    logic                  rd_addr_valid;
    logic                  rd_addr_ready;
    logic                  cmd_drop;
    logic [1:0]            rdy_mode;    // 0 held low, 1 held high, 2 random gaps
    logic [31:0]           stim_seed;
    logic [31:0]           rdy_seed;
    logic [31:0]           frame [$];   // words of the next frame
    int                    n;

    udp_axi_cmd u_dut (.*);

    udp_axi_cmd_monitor u_mon (.*);

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // {wr, id, addr, len, burst} from the head field layout
    function automatic logic [44:0] expected_issue(input logic [31:0] hi, input logic [31:0] lo);
        return {hi[16], hi[21:20], lo, hi[15:8], hi[23:22]};
    endfunction

    task automatic add_head(input logic [7:0] opcode, input bit expect_it, input bit force_wr);
        logic [31:0] hi;
        stim_seed = lcg(stim_seed);
        hi = {opcode, stim_seed[31:28], 3'b000, stim_seed[27] | force_wr,
              stim_seed[23:16], 8'h00};
        stim_seed = lcg(stim_seed);
        frame.push_back(hi);
        frame.push_back(stim_seed);
        if (expect_it && opcode == op_addr)
            u_mon.expect_item(expected_issue(hi, stim_seed));
    endtask

    task automatic send_frame();
        foreach (frame[i]) begin
            @(posedge gmii_rx_clk);
            #1;
            udp_rx_en   = 1'b1;
            udp_rx_data = frame[i];
            udp_rx_done = (i == frame.size() - 1);
        end
        @(posedge gmii_rx_clk);
        #1;
        udp_rx_en   = 1'b0;
        udp_rx_done = 1'b0;
        frame.delete();
    endtask

    task automatic wait_drain();
        int cyc;
        cyc = 0;
        while (u_mon.pending() != 0 && cyc < 1000) begin
            @(posedge gmii_rx_clk);
            #2;
            cyc++;
        end
        if (u_mon.pending() != 0)
            u_mon.report_error("timeout waiting for the expected address transfers");
        repeat (8) @(posedge gmii_rx_clk);  // room for stray transfers
        #2;
    endtask

    initial begin
        gmii_rx_clk = 1'b0;
        forever #5 gmii_rx_clk = ~gmii_rx_clk;
    end

    // ready driver, own random stream
    initial begin
        wr_addr_ready = 1'b0;
        rd_addr_ready = 1'b0;
        rdy_seed      = 32'h20dc_f310;
        forever begin
            @(posedge gmii_rx_clk);
            #1;
            rdy_seed      = lcg(rdy_seed);
            wr_addr_ready = (rdy_mode == 2'd2) ? rdy_seed[31] : rdy_mode[0];
            rd_addr_ready = (rdy_mode == 2'd2) ? rdy_seed[30] : rdy_mode[0];
        end
    end

    initial begin
        rstn        = 1'b0;
        udp_rx_en   = 1'b0;
        udp_rx_data = '0;
        udp_rx_done = 1'b0;
        rdy_mode    = 2'd1;
        stim_seed   = 32'h20dc_f310;
        repeat (2) @(posedge gmii_rx_clk);
        #1;
        rstn = 1'b1;

        u_mon.start_test("reset_values");
        u_mon.check_value("wr_addr_valid", 0, wr_addr_valid);
        u_mon.check_value("rd_addr_valid", 0, rd_addr_valid);
        u_mon.check_value("cmd_drop", 0, cmd_drop);
        u_mon.finish_test(0);

        u_mon.start_test("single_head_latency");
        add_head(op_addr, 1'b1, 1'b1);
        send_frame();
        n = 0;  // edges after the one that took the second word
        while (!wr_addr_valid && n < 20) begin
            @(posedge gmii_rx_clk);
            #1;
            n++;
        end
        if (!wr_addr_valid)
            u_mon.report_error("timeout waiting for wr_addr_valid");
        u_mon.check_value("valid latency", 3, n);
        wait_drain();
        u_mon.finish_test(0);

        u_mon.start_test("mixed_frame");
        rdy_mode = 2'd2;
        repeat (8) add_head(op_addr, 1'b1, 1'b0);
        send_frame();
        wait_drain();
        u_mon.finish_test(0);

        u_mon.start_test("non_address_heads");
        add_head(op_addr, 1'b1, 1'b0);
        add_head(8'h5A, 1'b1, 1'b0);        // nonzero opcode field, discarded
        send_frame();
        frame.push_back({op_wdata, 24'h0});
        add_head(op_addr, 1'b0, 1'b0);      // head look-alike inside a data frame
        send_frame();
        wait_drain();
        u_mon.finish_test(0);

        u_mon.start_test("overflow");
        rdy_mode = 2'd0;
        // the issuer holds one head on top of the full queue
        for (int i = 0; i < head_q_depth + 4; i++)
            add_head(op_addr, i < head_q_depth + 1, 1'b0);
        send_frame();
        repeat (4) @(posedge gmii_rx_clk);
        #1;
        rdy_mode = 2'd2;
        wait_drain();
        u_mon.finish_test(3);

        $display("tests: %0d passed, %0d failed, assertion failures: %0d",
                 u_mon.n_pass, u_mon.n_fail, u_dut.u_issuer.u_chk.fails);
        if (u_mon.n_fail == 0 && u_dut.u_issuer.u_chk.fails == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== udp_axi_cmd.f ====
cmd_frame_pkg.sv
axi_addr_pkg.sv
head_q_if.sv
cmd_frame_parser.sv
cmd_head_fifo.sv
axi_addr_issuer.sv
udp_axi_cmd.sv
udp_axi_cmd_chk.sv
udp_axi_cmd_monitor.sv
tb_udp_axi_cmd.sv
